// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pim_aes -f verilog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_pim_aes > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

// File: src/bit_plane_gather.sv
// bit-plane collector; gathered forwards the planes of the current rd_done cycle when sample is high
`timescale 1ns/1ps

module bit_plane_gather (
    input  logic                            CLK,
    input  logic                            rst,
    input  logic                            sample,
    input  pim_aes_pkg::beat_t              beat,
    input  logic [pim_aes_pkg::state_w-1:0] rio,
    output logic [pim_aes_pkg::state_w-1:0] gathered
);
    import pim_aes_pkg::*;

    logic [7:0] byte_q [byte_cnt];
    logic [7:0] plane_lo;
    logic [7:0] plane_hi;
    logic [3:0] lo_idx;
    logic [3:0] hi_idx;

    // ------------------------------
    // plane extraction
    // ------------------------------
    // beat k carries bit 7-k of every returned byte
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            plane_lo[i] = rio[(byte_cnt - 1 - i) * 8 + (7 - int'(beat))];
            plane_hi[i] = rio[(byte_cnt - 9 - i) * 8 + (7 - int'(beat))];
        end
    end

    assign lo_idx = {beat, 1'b0};
    assign hi_idx = {beat, 1'b1};

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            for (int j = 0; j < byte_cnt; j++) begin
                byte_q[j] <= '0;
            end
        end else if (sample) begin
            byte_q[lo_idx] <= plane_lo;
            byte_q[hi_idx] <= plane_hi;
        end
    end

    // ------------------------------
    // output view
    // ------------------------------
    // bypass lets the finish edge see bytes 14 and 15 of the last beat
    always_comb begin
        for (int j = 0; j < byte_cnt; j++) begin
            gathered[(byte_cnt - 1 - j) * 8 +: 8] = byte_q[j];
        end
        if (sample) begin
            gathered[(byte_cnt - 1 - int'(lo_idx)) * 8 +: 8] = plane_lo;
            gathered[(byte_cnt - 1 - int'(hi_idx)) * 8 +: 8] = plane_hi;
        end
    end

endmodule

// File: src/lookup_addresser.sv
// array address driver and result register; keys sit at row group/4, demux 7-(group mod 4)
`timescale 1ns/1ps

module lookup_addresser #(
    parameter int n_rounds = 10
) (
    input  logic                                                  CLK,
    input  logic                                                  rst,
    input  pim_aes_pkg::phase_t                                   phase,
    input  pim_aes_pkg::group_t                                   group,
    input  logic [pim_aes_pkg::state_w-1:0]                       gathered,
    input  logic                                                  finish,
    output logic [pim_aes_pkg::byte_cnt*pim_aes_pkg::demux_w-1:0] demux_addr,
    output logic [pim_aes_pkg::byte_cnt*pim_aes_pkg::row_w-1:0]   rwl_addr,
    output logic [pim_aes_pkg::state_w-1:0]                       dout,
    output logic                                                  valid
);
    import pim_aes_pkg::*;

    logic [demux_w-1:0] key_demux;
    logic [row_w-1:0]   key_row;
    logic [7:0]         lk_byte;

    // key slot of the current group, n_rounds+1 keys stored
    assign key_demux = 3'd7 - {1'b0, group[1:0]};
    assign key_row   = row_w'(group[3:2]);

    // ------------------------------
    // address fields, field 0 on top
    // ------------------------------
    always_comb begin
        demux_addr = '0;
        rwl_addr   = '0;
        lk_byte    = '0;
        for (int j = 0; j < byte_cnt; j++) begin
            lk_byte = gathered[(byte_cnt - 1 - j) * 8 +: 8];
            case (phase)
                WRITE: begin
                    demux_addr[(byte_cnt - 1 - j) * demux_w +: demux_w] = key_demux;
                    rwl_addr[(byte_cnt - 1 - j) * row_w +: row_w]       = key_row;
                end
                LOOKUP: begin
                    // table split over demux 0..3, 64 rows each
                    demux_addr[(byte_cnt - 1 - j) * demux_w +: demux_w] = {1'b0, lk_byte[7:6]};
                    rwl_addr[(byte_cnt - 1 - j) * row_w +: row_w]       = lk_byte[5:0];
                end
                default: begin
                end
            endcase
        end
    end

    // result of the final key add
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            dout  <= '0;
            valid <= 1'b0;
        end else begin
            valid <= finish;
            if (finish) begin
                dout <= gathered;
            end
        end
    end

endmodule

// File: src/pim_aes_ctrl.sv
// PIM AES controller top; n_rounds must be 1..11 and the array must answer every io_en once
`timescale 1ns/1ps

module pim_aes_ctrl #(
    parameter int n_rounds = 10
) (
    input  logic                                                  CLK,
    input  logic                                                  rst,
    input  logic                                                  start,
    input  logic [pim_aes_pkg::state_w-1:0]                       din,
    input  logic                                                  rd_done,
    input  logic [pim_aes_pkg::state_w-1:0]                       rio,
    output logic [pim_aes_pkg::state_w-1:0]                       dout,
    output logic                                                  valid,
    output logic                                                  busy,
    output logic                                                  io_en,
    output logic [pim_aes_pkg::slice_w-1:0]                       in_slice,
    output logic                                                  sel_ad0,
    output logic [pim_aes_pkg::byte_cnt*pim_aes_pkg::demux_w-1:0] demux_addr,
    output logic [pim_aes_pkg::byte_cnt*pim_aes_pkg::row_w-1:0]   rwl_addr
);
    import pim_aes_pkg::*;

    phase_t               phase;
    beat_t                beat;
    group_t               group;
    logic                 load_din;
    logic                 sample;
    logic                 load_lookup;
    logic                 finish;
    logic [state_w-1:0]   gathered;

    // phase, counters and the request pulse
    round_sequencer #(.n_rounds(n_rounds)) i_seq (
        .CLK(CLK), .rst(rst), .start(start), .rd_done(rd_done),
        .phase(phase), .beat(beat), .group(group),
        .load_din(load_din), .sample(sample), .load_lookup(load_lookup),
        .finish(finish), .busy(busy), .io_en(io_en), .sel_ad0(sel_ad0)
    );

    // producer, holds the round state
    slice_streamer i_stream (
        .CLK(CLK), .rst(rst), .load_din(load_din), .load_lookup(load_lookup),
        .din(din), .rio(rio), .phase(phase), .beat(beat),
        .in_slice(in_slice)
    );

    // key-added bytes rebuilt from bit planes
    bit_plane_gather i_gather (
        .CLK(CLK), .rst(rst), .sample(sample), .beat(beat), .rio(rio),
        .gathered(gathered)
    );

    // consumer, address outputs and result
    lookup_addresser #(.n_rounds(n_rounds)) i_addr (
        .CLK(CLK), .rst(rst), .phase(phase), .group(group),
        .gathered(gathered), .finish(finish),
        .demux_addr(demux_addr), .rwl_addr(rwl_addr), .dout(dout), .valid(valid)
    );

endmodule

// File: src/pim_aes_pkg.sv
// shared widths and phase codes; the row code holds group/4, so at most 12 groups fit
package pim_aes_pkg;

    // ------------------------------
    // datapath widths and counts
    // ------------------------------
    localparam int state_w  = 128;
    localparam int slice_w  = 16;
    localparam int n_beats  = 8;
    localparam int byte_cnt = 16;

    // array address fields, one pair per byte lane
    localparam int demux_w = 3;
    localparam int row_w   = 6;

    // ------------------------------
    // sequencer phases
    // ------------------------------
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        WRITE  = 3'd1,
        LOOKUP = 3'd2,
        DONE   = 3'd3
    } phase_t;

    // slice index within a group
    typedef logic [2:0] beat_t;
    // round group index, 0 .. n_rounds
    typedef logic [3:0] group_t;

endpackage

// File: src/round_sequencer.sv
// phase FSM for the array handshake; expects exactly one rd_done per io_en, never in the same cycle
`timescale 1ns/1ps

module round_sequencer #(
    parameter int n_rounds = 10
) (
    input  logic                CLK,
    input  logic                rst,
    input  logic                start,
    input  logic                rd_done,
    output pim_aes_pkg::phase_t phase,
    output pim_aes_pkg::beat_t  beat,
    output pim_aes_pkg::group_t group,
    output logic                load_din,
    output logic                sample,
    output logic                load_lookup,
    output logic                finish,
    output logic                busy,
    output logic                io_en,
    output logic                sel_ad0
);
    import pim_aes_pkg::*;

    phase_t prev_phase;
    logic   last_beat;
    logic   last_group;
    logic   entered;

    assign last_beat  = (beat == beat_t'(n_beats - 1));
    assign last_group = (group == group_t'(n_rounds));

    // strobes to the datapath blocks
    assign load_din    = (phase == IDLE) && start;
    assign sample      = (phase == WRITE) && rd_done;
    assign load_lookup = (phase == LOOKUP) && rd_done;
    assign finish      = sample && last_beat && last_group;

    assign busy    = (phase != IDLE);
    assign sel_ad0 = (phase == WRITE);

    // first cycle spent in a transaction phase
    assign entered = (phase != prev_phase) && ((phase == WRITE) || (phase == LOOKUP));

    // ------------------------------
    // phase and counters
    // ------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            phase <= IDLE;
            beat  <= '0;
            group <= '0;
        end else begin
            case (phase)
                IDLE: begin
                    if (start) begin
                        phase <= WRITE;
                        beat  <= '0;
                        group <= '0;
                    end
                end
                WRITE: begin
                    if (rd_done) begin
                        if (last_beat) begin
                            beat  <= '0;
                            // no lookup after the last key add
                            phase <= last_group ? DONE : LOOKUP;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                LOOKUP: begin
                    if (rd_done) begin
                        group <= group + 1'b1;
                        phase <= WRITE;
                    end
                end
                default: begin
                    phase <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // request pulse
    // ------------------------------
    // one pulse on phase entry, and one after every non-final write beat
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            io_en      <= 1'b0;
            prev_phase <= IDLE;
        end else begin
            io_en      <= entered || (sample && !last_beat);
            prev_phase <= phase;
        end
    end

endmodule

// File: src/slice_streamer.sv
// round state holder; in_slice is only meaningful while the phase is WRITE, zero otherwise
`timescale 1ns/1ps

module slice_streamer (
    input  logic                            CLK,
    input  logic                            rst,
    input  logic                            load_din,
    input  logic                            load_lookup,
    input  logic [pim_aes_pkg::state_w-1:0] din,
    input  logic [pim_aes_pkg::state_w-1:0] rio,
    input  pim_aes_pkg::phase_t             phase,
    input  pim_aes_pkg::beat_t              beat,
    output logic [pim_aes_pkg::slice_w-1:0] in_slice
);
    import pim_aes_pkg::*;

    logic [state_w-1:0] state_q;
    logic [6:0]         slice_lsb;

    // new run takes din, a finished lookup takes the looked-up bytes
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            state_q <= '0;
        end else if (load_din) begin
            state_q <= din;
        end else if (load_lookup) begin
            state_q <= rio;
        end
    end

    // beat 0 is the most significant slice
    assign slice_lsb = 7'((n_beats - 1 - int'(beat)) * slice_w);

    assign in_slice = (phase == WRITE) ? state_q[slice_lsb +: slice_w] : '0;

endmodule

// File: tests/array_model.sv
// behavioral PIM array; answers each io_en once after 1 to 4 cycles, counts write beats mod 8
`timescale 1ns/1ps

module array_model (
    input  logic         CLK,
    input  logic         rst,
    input  logic         io_en,
    input  logic         sel_ad0,
    input  logic [15:0]  in_slice,
    input  logic [47:0]  demux_addr,
    input  logic [95:0]  rwl_addr,
    output logic         rd_done,
    output logic [127:0] rio
);
    logic [127:0] key_tab [11];
    logic [7:0]   byte_tab [256];
    logic [15:0]  lfsr;
    logic [2:0]   wr_beat;
    logic [1:0]   wait_cnt;
    logic         pending;

    // galois lfsr, one bit per step
    function automatic logic draw_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        return b;
    endfunction

    // ------------------------------
    // array response
    // ------------------------------
    function automatic logic [127:0] answer();
        logic [127:0] r;
        logic [15:0]  x;
        int           key_idx;
        r = '1;
        if (sel_ad0) begin
            // key slot from field 0, spread as bit 7-k of every byte
            key_idx = int'(rwl_addr[95:90]) * 4 + (7 - int'(demux_addr[47:45]));
            x = in_slice ^ key_tab[key_idx][(7 - int'(wr_beat)) * 16 +: 16];
            for (int i = 0; i < 8; i++) begin
                r[(15 - i) * 8 + 7 - int'(wr_beat)] = x[8 + i];
                r[(7 - i) * 8 + 7 - int'(wr_beat)]  = x[i];
            end
        end else begin
            for (int j = 0; j < 16; j++) begin
                r[(15 - j) * 8 +: 8] = byte_tab[{demux_addr[(15 - j) * 3 +: 2],
                                                 rwl_addr[(15 - j) * 6 +: 6]}];
            end
        end
        return r;
    endfunction

    initial begin
        logic [1:0] d;
        rd_done <= 1'b0;
        rio     <= '0;
        lfsr = 16'd91;
        for (int k = 0; k < 11; k++) begin
            for (int b = 0; b < 128; b++) begin
                key_tab[k][b] = draw_bit();
            end
        end
        for (int e = 0; e < 256; e++) begin
            for (int b = 0; b < 8; b++) begin
                byte_tab[e][b] = draw_bit();
            end
        end
        forever begin
            @(posedge CLK or posedge rst);
            if (rst) begin
                rd_done  <= 1'b0;
                rio      <= '0;
                pending  <= 1'b0;
                wait_cnt <= '0;
                wr_beat  <= '0;
            end else begin
                rd_done <= 1'b0;
                if (io_en || pending) begin
                    d = io_en ? {draw_bit(), draw_bit()} : wait_cnt;
                    if (d == 2'd0) begin
                        rd_done <= 1'b1;
                        rio     <= answer();
                        pending <= 1'b0;
                        if (sel_ad0) begin
                            wr_beat <= wr_beat + 3'd1;
                        end
                    end else begin
                        pending  <= 1'b1;
                        wait_cnt <= d - 2'd1;
                    end
                end
            end
        end
    end

endmodule

// File: tests/tb_pim_aes.sv
// testbench for pim_aes_ctrl at n_rounds 10; reference reads the key and byte tables of the array
`timescale 1ns/1ps

module tb_pim_aes;
    localparam int n_rounds    = 10;
    localparam int n_runs      = 5;
    localparam int n_pulses    = 8 * (n_rounds + 1) + n_rounds;
    localparam int run_limit   = (n_rounds + 1) * 9 * 6;
    localparam int watchdog_ns = n_runs * run_limit * 40 + 20000;

    logic         CLK;
    logic         rst;
    logic         start;
    logic [127:0] din;
    logic         rd_done;
    logic [127:0] rio;
    logic [127:0] dout;
    logic         valid;
    logic         busy;
    logic         io_en;
    logic [15:0]  in_slice;
    logic         sel_ad0;
    logic [47:0]  demux_addr;
    logic [95:0]  rwl_addr;

    logic [15:0]  lfsr;
    int           test_errs;
    int           mon_errs;
    int           tests_run;
    int           tests_failed;

    pim_aes_ctrl #(.n_rounds(n_rounds)) i_dut (
        .CLK(CLK), .rst(rst), .start(start), .din(din), .rd_done(rd_done), .rio(rio),
        .dout(dout), .valid(valid), .busy(busy), .io_en(io_en), .in_slice(in_slice),
        .sel_ad0(sel_ad0), .demux_addr(demux_addr), .rwl_addr(rwl_addr)
    );

    array_model i_array (
        .CLK(CLK), .rst(rst), .io_en(io_en), .sel_ad0(sel_ad0), .in_slice(in_slice),
        .demux_addr(demux_addr), .rwl_addr(rwl_addr), .rd_done(rd_done), .rio(rio)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before all tests finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------
    // reference model and helpers
    // ------------------------------
    function automatic logic [127:0] expected_dout(input logic [127:0] value);
        logic [127:0] s;
        logic [127:0] a;
        s = value;
        a = '0;
        for (int g = 0; g <= n_rounds; g++) begin
            a = s ^ i_array.key_tab[g];
            for (int b = 0; b < 16; b++) begin
                s[(15 - b) * 8 +: 8] = i_array.byte_tab[a[(15 - b) * 8 +: 8]];
            end
        end
        return a;
    endfunction

    function automatic logic [127:0] random_state();
        logic [127:0] v;
        for (int b = 127; b >= 0; b--) begin
            v[b] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (test_errs + mon_errs != errs_before) begin
            tests_failed++;
        end
        $display("test %s: %s", name, (test_errs + mon_errs == errs_before) ? "ok" : "failed");
    endtask

    // one full run, optionally with a second start while busy
    task automatic run_once(input logic [127:0] value, input bit poke);
        logic [127:0] want;
        int           waited;
        want = expected_dout(value);
        @(posedge CLK);
        start <= 1'b1;
        din   <= value;
        @(posedge CLK);
        start <= 1'b0;
        if (poke) begin
            repeat (30) @(posedge CLK);
            start <= 1'b1;
            din   <= ~value;
            @(posedge CLK);
            start <= 1'b0;
        end
        waited = 0;
        @(negedge CLK);
        while (!valid && waited < run_limit) begin
            @(negedge CLK);
            waited++;
        end
        assert (valid) else begin
            $display("No valid within %0d cycles of start at %0t", run_limit, $time);
            test_errs++;
        end
        check_value("dout", dout, want);
        repeat (3) @(negedge CLK);
        check_value("valid", 128'(valid), '0);
        check_value("busy", 128'(busy), '0);
    endtask

    // ------------------------------
    // protocol monitor
    // ------------------------------
    logic         io_en_q;
    logic         valid_q;
    logic         accept_q;
    logic         open_q;
    logic         running;
    logic         sel_q;
    logic [15:0]  slice_q;
    logic [47:0]  demux_q;
    logic [95:0]  row_q;
    int           pulses;

    task automatic protocol_error(input string what);
        $display("Protocol error at %0t: %s", $time, what);
        mon_errs++;
    endtask

    always @(posedge CLK) begin
        logic fields_same;
        fields_same = 1'b1;
        for (int j = 1; j < 16; j++) begin
            fields_same &= (demux_addr[(15 - j) * 3 +: 3] == demux_addr[47:45]);
        end
        if (rst) begin
            io_en_q  <= 1'b0;
            valid_q  <= 1'b0;
            accept_q <= 1'b0;
            open_q   <= 1'b0;
            running  <= 1'b0;
            pulses   <= 0;
        end else begin
            io_en_q  <= io_en;
            valid_q  <= valid;
            accept_q <= start && !busy;
            assert (!(io_en && io_en_q)) else protocol_error("io_en high two cycles in a row");
            assert (!(valid && valid_q)) else protocol_error("valid high for more than one cycle");
            assert (!accept_q || busy) else protocol_error("busy did not rise after start");
            assert (!running || busy) else protocol_error("busy fell before valid");
            assert (!sel_ad0 || fields_same) else protocol_error("write demux fields differ");
            if (start && !busy) begin
                running <= 1'b1;
                pulses  <= 0;
            end
            if (io_en) begin
                assert (!open_q) else protocol_error("io_en issued before rd_done");
                open_q  <= 1'b1;
                sel_q   <= sel_ad0;
                slice_q <= in_slice;
                demux_q <= demux_addr;
                row_q   <= rwl_addr;
                pulses  <= pulses + 1;
            end else if (open_q) begin
                assert (in_slice == slice_q && demux_addr == demux_q && rwl_addr == row_q
                        && sel_ad0 == sel_q)
                    else protocol_error("array inputs changed during a transaction");
            end
            if (rd_done) begin
                assert (open_q) else protocol_error("rd_done without an open transaction");
                open_q <= 1'b0;
            end
            if (valid) begin
                assert (running) else protocol_error("valid without a run");
                assert (pulses == n_pulses)
                    else protocol_error($sformatf("run issued %0d io_en pulses", pulses));
                running <= 1'b0;
            end
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        int errs;
        lfsr = 16'd91;
        rst   <= 1'b1;
        start <= 1'b0;
        din   <= '0;
        repeat (10) @(posedge CLK);
        rst <= 1'b0;
        repeat (2) @(negedge CLK);
        check_value("valid", 128'(valid), '0);
        check_value("busy", 128'(busy), '0);
        check_value("io_en", 128'(io_en), '0);
        check_value("sel_ad0", 128'(sel_ad0), '0);
        check_value("dout", dout, '0);
        end_test("reset values", 0);
        for (int r = 0; r < n_runs - 1; r++) begin
            errs = test_errs + mon_errs;
            run_once(random_state(), 1'b0);
            end_test($sformatf("random run %0d", r), errs);
        end
        errs = test_errs + mon_errs;
        run_once(random_state(), 1'b1);
        end_test("start while busy", errs);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 test_errs + mon_errs);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
src/pim_aes_pkg.sv
src/round_sequencer.sv
src/slice_streamer.sv
src/bit_plane_gather.sv
src/lookup_addresser.sv
src/pim_aes_ctrl.sv
tests/array_model.sv
tests/tb_pim_aes.sv
